// File: Bender.yml
package:
  name: audio_mixer

sources:
  - include_dirs:
      - include
    files:
      - source/audio_types_pkg.sv
      - source/mixer_ctrl_pkg.sv
      - source/mixer_front.sv
      - source/interp_stage.sv
      - source/mixer_sum.sv
      - source/audio_mixer.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/mixer_checker.sv
      - bench/tb_audio_mixer.sv

// File: bench/mixer_checker.sv
/*
 * strobe assertions on audio_mixer, attached with bind
 * failures also count up fail_count for the testbench verdict
 */
`include "mixer_macros.svh"

module mixer_checker (
	input logic clk,
	input logic rst_int,
	input logic sample,
	input logic front_strobe,
	input logic fm6_strobe,
	input logic sum_strobe,
	input logic out_strobe
);

	int fail_count = 0;

	// 4x output keeps at least MIX_SP4 clocks between strobes
	a_out_spacing: assert property (@(posedge clk) disable iff (rst_int)
		out_strobe |=> (!out_strobe) [*(`MIX_SP4 - 1)])
	else begin
		fail_count++;
		$error("output strobes closer than %0d clocks", `MIX_SP4);
	end

	// whole strobe chain quiet in reset
	a_reset_quiet: assert property (@(posedge clk)
		rst_int |-> !(front_strobe || fm6_strobe || sum_strobe || out_strobe))
	else begin
		fail_count++;
		$error("strobe active while rst_int is high");
	end

	// front, 6x, sum and 4x each add one clock
	a_first_latency: assert property (@(posedge clk) disable iff (rst_int)
		sample |-> ##1 (!out_strobe) [*3] ##1 out_strobe)
	else begin
		fail_count++;
		$error("first output strobe not 4 clocks after sample");
	end

endmodule

// File: bench/tb_audio_mixer.sv
/*
 * testbench for audio_mixer, one sample every MIX_MIN_PERIOD clocks
 * the model predicts cycle and both channels of every output strobe
 */
`include "mixer_macros.svh"

module tb_audio_mixer
	import audio_types_pkg::*;
	import mixer_ctrl_pkg::*;
();

	localparam int N_FIXED = 15;
	localparam int N_ROWS = N_FIXED + 5;
	localparam int MAX_SAMPLES = 4;
	localparam int PERIOD = `MIX_MIN_PERIOD;
	// reset and idle time at the start fit well inside the margin
	localparam int LIMIT = N_ROWS * MAX_SAMPLES * PERIOD + 400;

	typedef struct packed {
		logic [31:0] cycle;
		sample_t left;
		sample_t right;
	} expect_t;

	typedef struct packed {
		logic [`MIX_FM_W-1:0] fm_left;
		logic [`MIX_FM_W-1:0] fm_right;
		logic [`MIX_PSG_W-1:0] psg;
		mix_ctrl_t ctrl;
		logic [2:0] count;
	} row_t;

	logic clk;
	logic rst;
	logic sample;
	logic signed [`MIX_FM_W-1:0] fm_left;
	logic signed [`MIX_FM_W-1:0] fm_right;
	logic [`MIX_PSG_W-1:0] psg;
	mix_ctrl_t ctrl;
	logic out_strobe;
	stereo_t out_data;

	row_t rows[N_ROWS];
	expect_t exp_q[$];
	expect_t exp_e;
	int cyc = 0;
	int errors = 0;
	int strobes = 0;
	int last_l = 0;
	int last_r = 0;
	// model smoothers, zero like the DUT after reset
	int y6_l = 0;
	int y6_r = 0;
	int y6_p = 0;
	int y4_l = 0;
	int y4_r = 0;

	audio_mixer audio_mixer_i (.*);

	bind audio_mixer mixer_checker u_checker (
		.clk          (clk),
		.rst_int      (rst_int),
		.sample       (sample),
		.front_strobe (front_strobe),
		.fm6_strobe   (fm6_strobe),
		.sum_strobe   (sum_strobe),
		.out_strobe   (out_strobe)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc == LIMIT) begin
			$display("timeout, output stream still running after %0d cycles", LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic int xorshift(input int s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return int'(x);
	endfunction

	// gated 12 bit sources
	function automatic int fm_in(input logic [`MIX_FM_W-1:0] v, input logic en);
		return en ? 8 * $signed(v) : 0;
	endfunction

	function automatic int psg_in(input logic [`MIX_PSG_W-1:0] v, input logic en);
		return en ? $signed(v) : 0;
	endfunction

	// y moves halfway to x, rounded down
	function automatic int smooth(input int y, input int x);
		return y + ((x - y) >>> `MIX_SMOOTH);
	endfunction

	// fm plus psg / 4, clamped to 12 bits, then the volume shift
	function automatic int mix(input int fm, input int p, input int vol);
		int s;
		s = fm + (p >>> 2);
		if (s > 2047) begin
			s = 2047;
		end else if (s < -2048) begin
			s = -2048;
		end
		return s >>> (7 - vol);
	endfunction

	function automatic row_t make_row(input int fl, input int fr, input int p,
			input bit ef, input bit ep, input int vol, input int cnt);
		row_t r;
		r.fm_left = `MIX_FM_W'(fl);
		r.fm_right = `MIX_FM_W'(fr);
		r.psg = `MIX_PSG_W'(p);
		r.ctrl.enable_fm = ef;
		r.ctrl.enable_psg = ep;
		r.ctrl.volume = 3'(vol);
		r.count = 3'(cnt);
		return r;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got %0h, expected %0h", name, got, exp);
		end
	endtask

	// 6 updates of the 6x stages, each followed by 4 updates of the 4x stage
	task automatic predict(input row_t r, input int base);
		int sl;
		int sr;
		expect_t e;
		for (int k = 0; k < `MIX_R6; k++) begin
			y6_l = smooth(y6_l, fm_in(r.fm_left, r.ctrl.enable_fm));
			y6_r = smooth(y6_r, fm_in(r.fm_right, r.ctrl.enable_fm));
			y6_p = smooth(y6_p, psg_in(r.psg, r.ctrl.enable_psg));
			sl = mix(y6_l, y6_p, r.ctrl.volume);
			sr = mix(y6_r, y6_p, r.ctrl.volume);
			for (int j = 0; j < `MIX_R4; j++) begin
				y4_l = smooth(y4_l, sl);
				y4_r = smooth(y4_r, sr);
				e.cycle = base + 4 + `MIX_SP6 * k + `MIX_SP4 * j;
				e.left = sample_t'(y4_l);
				e.right = sample_t'(y4_r);
				exp_q.push_back(e);
			end
		end
	endtask

	task automatic apply_row(input row_t r);
		for (int n = 0; n < r.count; n++) begin
			fm_left = r.fm_left;
			fm_right = r.fm_right;
			psg = r.psg;
			ctrl = r.ctrl;
			sample = 1'b1;
			predict(r, cyc);
			@(negedge clk);
			sample = 1'b0;
			repeat (PERIOD - 1) @(negedge clk);
		end
	endtask

	// smoothers round down, so the output may stop up to 3 below the mix
	task automatic settle_check(input row_t r);
		int p;
		int want_l;
		int want_r;
		p = psg_in(r.psg, r.ctrl.enable_psg);
		want_l = mix(fm_in(r.fm_left, r.ctrl.enable_fm), p, r.ctrl.volume);
		want_r = mix(fm_in(r.fm_right, r.ctrl.enable_fm), p, r.ctrl.volume);
		if (want_l - last_l < 0 || want_l - last_l > 3 ||
				want_r - last_r < 0 || want_r - last_r > 3) begin
			errors++;
			$display("output %0d/%0d did not settle at the mixed value %0d/%0d",
				last_l, last_r, want_l, want_r);
		end
	endtask

	// outputs sampled on the falling edge, half a clock after they change
	always @(negedge clk) begin
		if (out_strobe) begin
			strobes++;
			last_l = out_data.left;
			last_r = out_data.right;
			if (exp_q.size() == 0) begin
				errors++;
				$display("output strobe at cycle %0d with no sample pending", cyc);
			end else begin
				exp_e = exp_q.pop_front();
				check("out_strobe cycle", cyc, exp_e.cycle);
				check("out_data.left", out_data.left, exp_e.left);
				check("out_data.right", out_data.right, exp_e.right);
			end
		end
	end

	initial begin
		int rng;
		int row_errs;
		int row_strobes;
		rst = 1'b1;
		sample = 1'b0;
		fm_left = '0;
		fm_right = '0;
		psg = '0;
		ctrl = '0;
		rng = 81431;
		// zero input, smoothing, psg only, fm only, both off
		rows[0] = make_row(0, 0, 'h000, 1, 1, 7, 1);
		rows[1] = make_row(100, -50, 'h190, 1, 1, 7, 4);
		rows[2] = make_row(200, -200, 'h3e8, 0, 1, 7, 3);
		rows[3] = make_row(-120, 90, 'h7d0, 1, 0, 7, 3);
		rows[4] = make_row(-120, 90, 'h7d0, 0, 0, 7, 4);
		for (int v = 0; v < 8; v++) begin
			rows[5 + v] = make_row(150, -150, 'h258, 1, 1, v, 2);
		end
		// full scale both ways, clamps instead of wrapping
		rows[13] = make_row(255, 255, 'h7ff, 1, 1, 7, 4);
		rows[14] = make_row(-256, -256, 'h800, 1, 1, 7, 4);
		for (int i = N_FIXED; i < N_ROWS; i++) begin
			rng = xorshift(rng);
			rows[i] = make_row(rng[8:0], rng[17:9], rng[29:18], rng[30], rng[31],
				rng[2:0], 1 + rng[7:3] % 3);
		end
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// rst_int follows 3 clocks later, then the idle output is checked
		repeat (5) @(negedge clk);
		check("out_strobe after reset", out_strobe, 0);
		check("out_data after reset", out_data, 0);
		repeat (20) @(negedge clk);
		for (int i = 0; i < N_ROWS; i++) begin
			row_errs = errors;
			row_strobes = strobes;
			apply_row(rows[i]);
			while (exp_q.size() != 0) @(negedge clk);
			check("strobe count", strobes - row_strobes, 24 * rows[i].count);
			if (rows[i].count >= 4) begin
				settle_check(rows[i]);
			end
			$display("row %0d: %0d samples, fm %0d psg %0d vol %0d, %0d errors", i,
				rows[i].count, rows[i].ctrl.enable_fm, rows[i].ctrl.enable_psg,
				rows[i].ctrl.volume, errors - row_errs);
		end
		$display("%0d rows, %0d output strobes, %0d check errors, %0d assertion failures",
			N_ROWS, strobes, errors, audio_mixer_i.u_checker.fail_count);
		if (errors == 0 && audio_mixer_i.u_checker.fail_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: flist.f
+incdir+include
source/audio_types_pkg.sv
source/mixer_ctrl_pkg.sv
source/mixer_front.sv
source/interp_stage.sv
source/mixer_sum.sv
source/audio_mixer.sv
bench/mixer_checker.sv
bench/tb_audio_mixer.sv

// File: include/mixer_macros.svh
/*
 * widths, rates and strobe timing of the output mixer
 * sample strobes must be at least MIX_MIN_PERIOD clocks apart,
 * a closer strobe restarts the 6x bursts and output strobes are lost
 */
`ifndef MIXER_MACROS_SVH
`define MIXER_MACROS_SVH

// raw source widths
`define MIX_FM_W 9
`define MIX_PSG_W 12

// common sample width inside the data path and at the output
`define MIX_W 12

// interpolation ratios of the two stages
`define MIX_R6 6
`define MIX_R4 4

// clocks between output strobes of each stage
`define MIX_SP6 28
`define MIX_SP4 7

// smoother step, y moves by (x - y) >>> MIX_SMOOTH per strobe
`define MIX_SMOOTH 1

// shortest legal input sample period in clocks
`define MIX_MIN_PERIOD ((`MIX_R6) * (`MIX_SP6))

`endif

// File: source/audio_mixer.sv
/*
 * FM and PSG output mixer, rate raised by 24 (6x, then 4x)
 * sample must be pulsed no more often than every MIX_MIN_PERIOD clocks
 * first output strobe comes 4 clocks after sample, then one every 7
 */
`include "mixer_macros.svh"

module audio_mixer
	import audio_types_pkg::*;
	import mixer_ctrl_pkg::*;
(
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         sample,
	input  logic signed [`MIX_FM_W-1:0]  fm_left,
	input  logic signed [`MIX_FM_W-1:0]  fm_right,
	input  logic        [`MIX_PSG_W-1:0] psg,
	input  mix_ctrl_t                    ctrl,
	output logic                         out_strobe,
	output stereo_t                      out_data
);

	logic      rst_int;
	logic      front_strobe;
	stereo_t   fm_frame;
	sample_t   psg_mono;
	mix_ctrl_t ctrl_q;
	logic      fm6_strobe;
	stereo_t   fm6_data;
	sample_t   psg6_data;
	logic      sum_strobe;
	stereo_t   sum_data;

	mixer_front u_front (
		.clk      (clk),
		.rst      (rst),
		.sample   (sample),
		.fm_left  (fm_left),
		.fm_right (fm_right),
		.psg      (psg),
		.ctrl     (ctrl),
		.rst_int  (rst_int),
		.strobe_q (front_strobe),
		.fm_frame (fm_frame),
		.psg_mono (psg_mono),
		.ctrl_q   (ctrl_q)
	);

	// 6x on the FM pair
	interp_stage #(
		.payload_t (stereo_t),
		.RATIO     (`MIX_R6),
		.SPACING   (`MIX_SP6)
	) u_fm6 (
		.clk        (clk),
		.rst        (rst_int),
		.in_strobe  (front_strobe),
		.in_data    (fm_frame),
		.out_strobe (fm6_strobe),
		.out_data   (fm6_data)
	);

	// 6x on the PSG, its strobes match u_fm6 so they are left open
	interp_stage #(
		.payload_t (sample_t),
		.RATIO     (`MIX_R6),
		.SPACING   (`MIX_SP6)
	) u_psg6 (
		.clk        (clk),
		.rst        (rst_int),
		.in_strobe  (front_strobe),
		.in_data    (psg_mono),
		.out_strobe (),
		.out_data   (psg6_data)
	);

	mixer_sum u_sum (
		.clk        (clk),
		.rst        (rst_int),
		.in_strobe  (fm6_strobe),
		.fm         (fm6_data),
		.psg        (psg6_data),
		.ctrl       (ctrl_q),
		.out_strobe (sum_strobe),
		.out_data   (sum_data)
	);

	// final 4x, 28 / 4 = 7 clocks between output strobes
	interp_stage #(
		.payload_t (stereo_t),
		.RATIO     (`MIX_R4),
		.SPACING   (`MIX_SP4)
	) u_out4 (
		.clk        (clk),
		.rst        (rst_int),
		.in_strobe  (sum_strobe),
		.in_data    (sum_data),
		.out_strobe (out_strobe),
		.out_data   (out_data)
	);

endmodule

// File: source/audio_types_pkg.sv
/*
 * sample types of the mixer data path
 * all samples are two's complement, MIX_W bits wide
 */
`include "mixer_macros.svh"

package audio_types_pkg;

	// one mono sample
	typedef logic signed [`MIX_W-1:0] sample_t;

	// stereo pair, left sits in the upper bits
	typedef struct packed {
		sample_t left;
		sample_t right;
	} stereo_t;

	// PSG is mono, it is added into both channels
	// so a single sample_t is enough to carry it

endpackage

// File: source/interp_stage.sv
/*
 * interpolator made of a zero-order hold and a first-order smoother
 * payload must be a whole number of MIX_W lanes (sample_t, stereo_t)
 * each input strobe gives RATIO output strobes, SPACING clocks apart
 * an input strobe inside a burst restarts it
 */
`include "mixer_macros.svh"

module interp_stage
	import audio_types_pkg::*;
#(
	parameter type payload_t = sample_t,
	parameter int  RATIO     = `MIX_R6,
	parameter int  SPACING   = `MIX_SP6
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     in_strobe,
	input  payload_t in_data,
	output logic     out_strobe,
	output payload_t out_data
);

	// payload is handled as a flat vector of sample lanes
	localparam int PW    = $bits(payload_t);
	localparam int LANES = PW / `MIX_W;
	localparam int RW    = $clog2(RATIO + 1);
	localparam int SW    = $clog2(SPACING + 1);

	logic [PW-1:0] in_bits;
	logic [PW-1:0] x_hold;
	logic [PW-1:0] x_src;
	logic [PW-1:0] y_q;
	logic [PW-1:0] y_next;
	logic [RW-1:0] burst_left;
	logic [SW-1:0] space_cnt;
	logic          fire;
	logic          strobe_q;

	assign in_bits = in_data;

	// an input strobe fires at once and the rest of the burst
	// fires whenever the spacing counter runs out
	assign fire = in_strobe || (burst_left != '0 && space_cnt == '0);

	// the first update of a burst uses the fresh input directly
	assign x_src = in_strobe ? in_bits : x_hold;

	// per lane smoother
	// 13 bit difference so that full scale steps do not wrap
	always_comb begin
		sample_t lane_x;
		sample_t lane_y;
		logic signed [`MIX_W:0] diff;
		logic signed [`MIX_W:0] lane_new;
		y_next = y_q;
		for (int l = 0; l < LANES; l++) begin
			lane_x   = x_src[l*`MIX_W +: `MIX_W];
			lane_y   = y_q[l*`MIX_W +: `MIX_W];
			diff     = lane_x - lane_y;
			// new value lies between x and y and fits in MIX_W bits
			lane_new = lane_y + (diff >>> `MIX_SMOOTH);
			y_next[l*`MIX_W +: `MIX_W] = lane_new[`MIX_W-1:0];
		end
	end

	// burst sequencer
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			burst_left <= '0;
			space_cnt  <= '0;
		end else if (in_strobe) begin
			// one strobe is issued now and RATIO - 1 are still to go
			burst_left <= RW'(RATIO - 1);
			space_cnt  <= SW'(SPACING - 1);
		end else if (burst_left != '0) begin
			if (space_cnt == '0) begin
				burst_left <= burst_left - 1'b1;
				space_cnt  <= SW'(SPACING - 1);
			end else begin
				space_cnt <= space_cnt - 1'b1;
			end
		end
	end

	// held value and output register
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			strobe_q <= 1'b0;
			y_q      <= '0;
		end else begin
			strobe_q <= fire;
			if (fire) begin
				y_q <= y_next;
			end
		end
	end

	// input held for the rest of the burst
	always_ff @(posedge clk) begin
		if (in_strobe) begin
			x_hold <= in_bits;
		end
	end

	assign out_strobe = strobe_q;
	assign out_data   = payload_t'(y_q);

endmodule

// File: source/mixer_ctrl_pkg.sv
/*
 * mixer control word
 * fields are levels, sampled on each input sample strobe
 * volume 7 is full scale, every step down halves the output
 */
package mixer_ctrl_pkg;

	// volume code width
	localparam int VOL_W = 3;

	typedef struct packed {
		// FM source on
		logic enable_fm;
		// PSG source on
		logic enable_psg;
		// output is shifted right by 7 - volume
		logic [VOL_W-1:0] volume;
	} mix_ctrl_t;

endpackage

// File: source/mixer_front.sv
/*
 * input side of the mixer
 * rst_int asserts with rst and releases 3 clocks after rst falls
 * sources and control are taken only when sample is high
 */
`include "mixer_macros.svh"

module mixer_front
	import audio_types_pkg::*;
	import mixer_ctrl_pkg::*;
(
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         sample,
	input  logic signed [`MIX_FM_W-1:0]  fm_left,
	input  logic signed [`MIX_FM_W-1:0]  fm_right,
	input  logic        [`MIX_PSG_W-1:0] psg,
	input  mix_ctrl_t                    ctrl,
	output logic                         rst_int,
	output logic                         strobe_q,
	output stereo_t                      fm_frame,
	output sample_t                      psg_mono,
	output mix_ctrl_t                    ctrl_q
);

	// padding that brings the FM sample up to MIX_W bits
	localparam int FM_PAD = `MIX_W - `MIX_FM_W;

	logic [2:0] rst_sr;
	stereo_t fm_gated;
	sample_t psg_gated;

	// local reset tree, the rest of the mixer hangs off rst_int
	// instead of loading the external reset
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rst_sr <= '1;
		end else begin
			rst_sr <= {rst_sr[1:0], 1'b0};
		end
	end

	assign rst_int = rst_sr[2];

	// FM is 9 bits, appending zeros is the same as sign extension
	// followed by a left shift of 3
	assign fm_gated.left  = ctrl.enable_fm ? {fm_left, {FM_PAD{1'b0}}} : '0;
	assign fm_gated.right = ctrl.enable_fm ? {fm_right, {FM_PAD{1'b0}}} : '0;

	// PSG level is reinterpreted as a signed value
	assign psg_gated = ctrl.enable_psg ? sample_t'(psg) : '0;

	always_ff @(posedge clk or posedge rst_int) begin
		if (rst_int) begin
			strobe_q <= 1'b0;
			fm_frame <= '0;
			psg_mono <= '0;
			ctrl_q   <= '0;
		end else begin
			// strobe marks the cycle in which the new values are visible
			strobe_q <= sample;
			if (sample) begin
				fm_frame <= fm_gated;
				psg_mono <= psg_gated;
				ctrl_q   <= ctrl;
			end
		end
	end

endmodule

// File: source/mixer_sum.sv
/*
 * adds the PSG (attenuated by 4) into both FM channels
 * sum is clamped to MIX_W bits, then shifted right by 7 - volume
 * fm and psg must come from stages with the same timing
 */
`include "mixer_macros.svh"

module mixer_sum
	import audio_types_pkg::*;
	import mixer_ctrl_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      in_strobe,
	input  stereo_t   fm,
	input  sample_t   psg,
	input  mix_ctrl_t ctrl,
	output logic      out_strobe,
	output stereo_t   out_data
);

	// PSG attenuation as a right shift
	localparam int PSG_ATT = 2;

	// clamp limits
	localparam sample_t SAT_MAX = {1'b0, {(`MIX_W-1){1'b1}}};
	localparam sample_t SAT_MIN = {1'b1, {(`MIX_W-1){1'b0}}};

	stereo_t mixed;

	// one channel: add, clamp, scale
	function automatic sample_t mix_channel(
		input sample_t              fm_v,
		input sample_t              psg_v,
		input logic [VOL_W-1:0]     vol
	);
		logic signed [`MIX_W:0] wide;
		sample_t sat;
		// 13 bits of headroom, psg_v is sign extended before the shift
		wide = fm_v + (psg_v >>> PSG_ATT);
		// top two bits differ only when the sum left the 12 bit range
		if (wide[`MIX_W] != wide[`MIX_W-1]) begin
			sat = wide[`MIX_W] ? SAT_MIN : SAT_MAX;
		end else begin
			sat = wide[`MIX_W-1:0];
		end
		// volume 7 passes through, volume 0 shifts by 7
		return sat >>> (3'd7 - vol);
	endfunction

	assign mixed.left  = mix_channel(fm.left, psg, ctrl.volume);
	assign mixed.right = mix_channel(fm.right, psg, ctrl.volume);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			out_strobe <= 1'b0;
			out_data   <= '0;
		end else begin
			out_strobe <= in_strobe;
			if (in_strobe) begin
				out_data <= mixed;
			end
		end
	end

endmodule
